// File: branch_miss_top.sv
/*
 * Branch-miss redirect path top level
 * Branch unit, redirect queue and fetch sequencer in a chain
 */
`timescale 1ns/1ps
`include "brm_config.svh"

module branch_miss_top
(
	input logic clk,
	input logic reset,
	input logic branch_valid,
	input brm_pkg::branch_req_t branch_req,
	input brm_pkg::pc_t [1:0] pc_stack,
	input logic fetch_stall,
	output brm_pkg::pc_t fetch_pc,
	output logic fetch_valid,
	output logic redirect_strobe,
	output logic overflow
);

logic push;
brm_pkg::redirect_t push_data;
logic pop;
brm_pkg::redirect_t head;
logic not_empty;

// Producer side, one miss record per mispredicted branch
branch_resolve u_resolve
(
	.clk(clk),
	.reset(reset),
	.branch_valid(branch_valid),
	.req(branch_req),
	.pc_stack(pc_stack),
	.push(push),
	.push_data(push_data)
);

// Records wait here while fetch is stalled
redirect_fifo u_fifo
(
	.clk(clk),
	.reset(reset),
	.push(push),
	.push_data(push_data),
	.pop(pop),
	.head(head),
	.not_empty(not_empty),
	.overflow(overflow)
);

fetch_sequencer u_fetch
(
	.clk(clk),
	.reset(reset),
	.not_empty(not_empty),
	.head(head),
	.fetch_stall(fetch_stall),
	.pop(pop),
	.fetch_pc(fetch_pc),
	.fetch_valid(fetch_valid),
	.redirect_strobe(redirect_strobe)
);

endmodule

// File: branch_resolve.sv
/*
 * Branch unit back half
 * Evaluates the compare condition, decides whether the prediction missed
 * and registers a miss record with a one-cycle push strobe
 */
`timescale 1ns/1ps
`include "brm_config.svh"

module branch_resolve
(
	input logic clk,
	input logic reset,
	input logic branch_valid,
	input brm_pkg::branch_req_t req,
	input brm_pkg::pc_t [1:0] pc_stack,
	output logic push,
	output brm_pkg::redirect_t push_data
);

logic cond_true;
logic takb;
logic miss;
brm_pkg::pc_t misspc;

// ====================
// Condition and outcome
// ====================

always_comb
begin
	case (req.op.cond)
	brm_pkg::CND_EQ:  cond_true = req.arg_a == req.arg_b;
	brm_pkg::CND_NE:  cond_true = req.arg_a != req.arg_b;
	brm_pkg::CND_LT:  cond_true = $signed(req.arg_a) < $signed(req.arg_b);
	brm_pkg::CND_GE:  cond_true = $signed(req.arg_a) >= $signed(req.arg_b);
	brm_pkg::CND_LTU: cond_true = req.arg_a < req.arg_b;
	brm_pkg::CND_GEU: cond_true = req.arg_a >= req.arg_b;
	default:          cond_true = 1'b0;
	endcase
end

always_comb
begin
	// Only the conditional classes depend on the compare
	case (req.op.brclass)
	brm_pkg::BRC_BCCD,
	brm_pkg::BRC_BCCR:
		takb = cond_true;
	default:
		takb = 1'b1;
	endcase

	// A miss is any case where fetch went somewhere other than the real path
	case (req.op.brclass)
	brm_pkg::BRC_BCCD,
	brm_pkg::BRC_BCCR:
		miss = req.bt != takb;
	// Subroutine calls are fine if the front end predicted them taken
	brm_pkg::BRC_JSR:
		miss = !req.bt;
	brm_pkg::BRC_RTD,
	brm_pkg::BRC_ERET:
		miss = 1'b1;
	default:
		miss = 1'b0;
	endcase
end

// Only the corrected fetch address goes into the miss record
branch_target_calc u_target
(
	.req(req),
	.pc_stack(pc_stack),
	.takb(takb),
	.dstpc(),
	.misspc(misspc)
);

// ====================
// Miss record register
// ====================

always_ff @(posedge clk)
begin
	if (reset)
		push <= 1'b0;
	else
		push <= branch_valid & miss;
end

// The record is only looked at while push is high
always_ff @(posedge clk)
begin
	if (branch_valid)
	begin
		push_data.misspc <= misspc;
		push_data.brclass <= req.op.brclass;
		push_data.takb <= takb;
	end
end

endmodule

// File: branch_target_calc.sv
/*
 * Branch destination and miss address computation
 * Purely combinational, one result per branch class
 */
`timescale 1ns/1ps
`include "brm_config.svh"

module branch_target_calc
(
	input brm_pkg::branch_req_t req,
	input brm_pkg::pc_t [1:0] pc_stack,
	input logic takb,
	output brm_pkg::pc_t dstpc,
	output brm_pkg::pc_t misspc
);

// Sign-extended displacement, already scaled from halfwords to bytes
brm_pkg::pc_t disp_ext;

// Address of the instruction that follows the branch
brm_pkg::pc_t fall_pc;

// Return-address stack entry picked by the exception return
brm_pkg::pc_t eret_base;

// Exception return offset converted from instructions to bytes
brm_pkg::pc_t eret_adj;

// ====================
// Address terms
// ====================

always_comb
begin
	// The displacement field holds halfwords, shift in a zero to get bytes
	disp_ext = {{(`BRM_ABITS-21){req.op.disp[19]}}, req.op.disp, 1'b0};
	fall_pc = req.pc + brm_pkg::pc_t'(`BRM_INSN_BYTES);
end

always_comb
begin
	// Entry 1 is the older saved address, used when eret_sel is set
	if (req.op.eret_sel)
		eret_base = pc_stack[1];
	else
		eret_base = pc_stack[0];
	// Offset counts whole instructions, each six bytes
	eret_adj = brm_pkg::pc_t'(req.op.eret_ofs) * brm_pkg::pc_t'(`BRM_INSN_BYTES);
end

// ====================
// Destination
// ====================

always_comb
begin
	case (req.op.brclass)
	brm_pkg::BRC_BCCD:
		dstpc = req.pc + disp_ext;
	// Register-indirect conditional branch takes its target from the third operand
	brm_pkg::BRC_BCCR:
		dstpc = req.arg_c;
	brm_pkg::BRC_JSR:
		dstpc = req.pc + disp_ext;
	// Return goes to the address held in the first operand
	brm_pkg::BRC_RTD:
		dstpc = req.arg_a;
	brm_pkg::BRC_ERET:
		dstpc = eret_base + eret_adj;
	default:
		// Not a branch, park the destination at the reset vector
		dstpc = `BRM_RSTPC;
	endcase
end

// ====================
// Corrected fetch address
// ====================

always_comb
begin
	case (req.op.brclass)
	brm_pkg::BRC_BCCD,
	brm_pkg::BRC_BCCR:
		begin
			// A conditional branch that was not taken resumes after itself
			if (takb)
				misspc = dstpc;
			else
				misspc = fall_pc;
		end
	default:
		// Unconditional classes always restart at their destination
		misspc = dstpc;
	endcase
end

endmodule

// File: brm_config.svh
/*
 * Build-time parameters of the branch-miss redirect path
 * Address width, queue depth, reset fetch address, instruction size
 */
`ifndef BRM_CONFIG_SVH
`define BRM_CONFIG_SVH

// ====================
// Datapath widths
// ====================

// Width of fetch addresses and operand values
`define BRM_ABITS 32

// ====================
// Redirect queue and fetch
// ====================

// Number of miss records held between the branch unit and fetch
// The pointers wrap by overflow so this has to be a power of two
`define BRM_FIFO_DEPTH 4

// Fetch restarts here after reset
`define BRM_RSTPC 32'hFFFC0000

// Every instruction is six bytes long
`define BRM_INSN_BYTES 6

`endif

// File: brm_pkg.sv
/*
 * Shared types of the branch-miss redirect path
 * Address and value vectors, branch class and compare codes,
 * the decoded branch request, the queue entry and the fetch FSM states
 */
`include "brm_config.svh"

package brm_pkg;

	// ====================
	// Vector types
	// ====================

	typedef logic [`BRM_ABITS-1:0] pc_t;
	typedef logic [`BRM_ABITS-1:0] value_t;
	typedef logic [2:0] brclass_t;
	typedef logic [2:0] cond_t;

	// Displacement counts halfwords, so it is doubled before the add
	typedef logic [19:0] disp_t;

	// Branch classes seen by the miss logic
	localparam brclass_t BRC_NONE = 3'd0;
	localparam brclass_t BRC_BCCD = 3'd1;
	localparam brclass_t BRC_BCCR = 3'd2;
	localparam brclass_t BRC_JSR  = 3'd3;
	localparam brclass_t BRC_RTD  = 3'd4;
	localparam brclass_t BRC_ERET = 3'd5;

	// Compare conditions, the last two treat the operands as unsigned
	localparam cond_t CND_EQ  = 3'd0;
	localparam cond_t CND_NE  = 3'd1;
	localparam cond_t CND_LT  = 3'd2;
	localparam cond_t CND_GE  = 3'd3;
	localparam cond_t CND_LTU = 3'd4;
	localparam cond_t CND_GEU = 3'd5;

	// ====================
	// Structures
	// ====================

	// Decoded micro-op fields that steer the target computation
	typedef struct packed {
		brclass_t brclass;
		cond_t cond;
		disp_t disp;
		logic eret_sel;
		logic [4:0] eret_ofs;
	} branch_op_t;

	// One resolved branch as issued to the branch unit
	typedef struct packed {
		branch_op_t op;
		pc_t pc;
		value_t arg_a;
		value_t arg_b;
		value_t arg_c;
		logic bt;
	} branch_req_t;

	// One queue entry, the corrected fetch address and what caused it
	typedef struct packed {
		pc_t misspc;
		brclass_t brclass;
		logic takb;
	} redirect_t;

	// Fetch sequencer states
	typedef enum logic [0:0] {
		FETCH_RUN,
		FETCH_FLUSH
	} fetch_state_t;

endpackage

// File: fetch_sequencer.sv
/*
 * Fetch address counter with restart FSM
 * Pops miss records and restarts fetch behind a one-cycle bubble
 */
`timescale 1ns/1ps
`include "brm_config.svh"

module fetch_sequencer
(
	input logic clk,
	input logic reset,
	input logic not_empty,
	input brm_pkg::redirect_t head,
	input logic fetch_stall,
	output logic pop,
	output brm_pkg::pc_t fetch_pc,
	output logic fetch_valid,
	output logic redirect_strobe
);

brm_pkg::fetch_state_t state;

// ====================
// Queue drain and fetch qualifier
// ====================

// Take a redirect whenever one is waiting and fetch may move
assign pop = not_empty & !fetch_stall;

// Flush cycles and stalled cycles deliver nothing to decode
assign fetch_valid = (state == brm_pkg::FETCH_RUN) & !fetch_stall;

// ====================
// Address counter and FSM
// ====================

always_ff @(posedge clk)
begin
	if (reset)
	begin
		state <= brm_pkg::FETCH_FLUSH;
		fetch_pc <= `BRM_RSTPC;
		redirect_strobe <= 1'b0;
	end
	else
	begin
		redirect_strobe <= 1'b0;
		if (pop)
		begin
			// Restart at the corrected address, whatever the current state
			fetch_pc <= head.misspc;
			state <= brm_pkg::FETCH_FLUSH;
			redirect_strobe <= 1'b1;
		end
		else if (!fetch_stall)
		begin
			// The flush bubble also moves the counter past the restart address
			fetch_pc <= fetch_pc + brm_pkg::pc_t'(`BRM_INSN_BYTES);
			state <= brm_pkg::FETCH_RUN;
		end
		// Stalled with nothing to pop, the address and the state hold
	end
end

endmodule

// File: redirect_fifo.sv
/*
 * Queue of miss records between the branch unit and fetch
 * Circular buffer with a sticky overflow flag
 */
`timescale 1ns/1ps
`include "brm_config.svh"

module redirect_fifo
(
	input logic clk,
	input logic reset,
	input logic push,
	input brm_pkg::redirect_t push_data,
	input logic pop,
	output brm_pkg::redirect_t head,
	output logic not_empty,
	output logic overflow
);

localparam int PTR_BITS = $clog2(`BRM_FIFO_DEPTH);
localparam logic [PTR_BITS:0] FULL_COUNT = `BRM_FIFO_DEPTH;

brm_pkg::redirect_t mem [`BRM_FIFO_DEPTH];
logic [PTR_BITS-1:0] wr_ptr;
logic [PTR_BITS-1:0] rd_ptr;
logic [PTR_BITS:0] count;
logic full;
logic do_push;
logic do_pop;

// ====================
// Status and qualifiers
// ====================

assign full = count == FULL_COUNT;
assign not_empty = count != '0;

// A push against a full queue is lost, even if a pop frees a slot this cycle
assign do_push = push & !full;
assign do_pop = pop & not_empty;

// Oldest record sits at the read pointer
assign head = mem[rd_ptr];

// ====================
// Storage
// ====================

always_ff @(posedge clk)
begin
	if (do_push)
		mem[wr_ptr] <= push_data;
end

// ====================
// Pointers and occupancy
// ====================

always_ff @(posedge clk)
begin
	if (reset)
	begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
		overflow <= 1'b0;
	end
	else
	begin
		// Pointers wrap on their own since the depth is a power of two
		if (do_push)
			wr_ptr <= wr_ptr + 1'b1;
		if (do_pop)
			rd_ptr <= rd_ptr + 1'b1;
		case ({do_push, do_pop})
		2'b10: count <= count + 1'b1;
		2'b01: count <= count - 1'b1;
		default: count <= count;
		endcase
		// Stays set until reset so a lost redirect is never missed
		if (push && full)
			overflow <= 1'b1;
	end
end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench and the DUT with Verilator, then runs the model
# A $fatal in the testbench gives a non-zero exit status
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_branch_miss \
	-o tb_branch_miss \
	&& ./obj_dir/tb_branch_miss \
	|| exit 1

// File: tb_branch_miss.sv
/*
 * Testbench for the branch-miss redirect path
 * Stimulus table with a reference model of the miss rules,
 * a scoreboard of expected restart addresses, a fetch monitor and a timeout
 */
`timescale 1ns/1ps
`include "brm_config.svh"

module tb_branch_miss;

localparam int MAX_ROWS = 128;

// One table row, the branch, the return stack seen with it and its stall length
typedef struct packed {
	brm_pkg::branch_req_t req;
	brm_pkg::pc_t [1:0] stack;
	logic [3:0] stall;
} row_t;

logic clk;
logic reset;
logic branch_valid;
brm_pkg::branch_req_t branch_req;
brm_pkg::pc_t [1:0] pc_stack;
logic fetch_stall;
brm_pkg::pc_t fetch_pc;
logic fetch_valid;
logic redirect_strobe;
logic overflow;

row_t rows [MAX_ROWS];
int num_rows;
integer seed;
int cycles = 0;
int cycle_limit = 0;
string test_name;
// Restart addresses still owed by the DUT, oldest first
brm_pkg::pc_t expect_q [$];
logic expect_ovf;

// Monitor state carried from one cycle to the next
logic started;
logic in_flush;
logic prev_stall;
brm_pkg::pc_t prev_pc;
brm_pkg::pc_t owed_pc;

branch_miss_top u_dut
(
	.clk(clk),
	.reset(reset),
	.branch_valid(branch_valid),
	.branch_req(branch_req),
	.pc_stack(pc_stack),
	.fetch_stall(fetch_stall),
	.fetch_pc(fetch_pc),
	.fetch_valid(fetch_valid),
	.redirect_strobe(redirect_strobe),
	.overflow(overflow)
);

initial
begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

// ====================
// Reporting
// ====================

task automatic abort_run(input string why);
	$display("Simulation failed");
	$fatal(1, "%s", why);
endtask

task automatic check_pc(input string what, input brm_pkg::pc_t exp, input brm_pkg::pc_t act);
	if (exp !== act)
	begin
		$display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
		abort_run("address mismatch");
	end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
	if (exp !== act)
	begin
		$display("ERROR %s %s: expected %b actual %b", test_name, what, exp, act);
		abort_run("flag mismatch");
	end
endtask

// Ends the run when the table takes far longer than its rows allow
always @(posedge clk)
begin
	cycles = cycles + 1;
	if (cycle_limit != 0 && cycles > cycle_limit)
	begin
		$display("The run did not finish within %0d cycles", cycle_limit);
		abort_run("timeout");
	end
end

// ====================
// Reference model
// ====================

// Returns 1 when the branch mispredicted, target gets the corrected fetch address
function automatic logic predict_miss(input brm_pkg::branch_req_t r,
	input brm_pkg::pc_t [1:0] stack, output brm_pkg::pc_t target);
	logic eq;
	logic lt_s;
	logic lt_u;
	logic taken;
	logic result;
	eq = r.arg_a == r.arg_b;
	lt_s = $signed(r.arg_a) < $signed(r.arg_b);
	lt_u = r.arg_a < r.arg_b;
	case (r.op.cond)
	brm_pkg::CND_EQ: taken = eq;
	brm_pkg::CND_NE: taken = !eq;
	brm_pkg::CND_LT: taken = lt_s;
	brm_pkg::CND_GE: taken = !lt_s;
	brm_pkg::CND_LTU: taken = lt_u;
	brm_pkg::CND_GEU: taken = !lt_u;
	default: taken = 1'b0;
	endcase
	// Displacement is in halfwords and signed
	case (r.op.brclass)
	brm_pkg::BRC_BCCD, brm_pkg::BRC_JSR:
		target = r.pc + (brm_pkg::pc_t'($signed(r.op.disp)) << 1);
	brm_pkg::BRC_BCCR: target = r.arg_c;
	brm_pkg::BRC_RTD: target = r.arg_a;
	brm_pkg::BRC_ERET:
		target = stack[r.op.eret_sel] + 32'(r.op.eret_ofs) * `BRM_INSN_BYTES;
	default: target = `BRM_RSTPC;
	endcase
	case (r.op.brclass)
	brm_pkg::BRC_BCCD, brm_pkg::BRC_BCCR:
	begin
		// A conditional branch that falls through restarts after itself
		if (!taken)
			target = r.pc + `BRM_INSN_BYTES;
		result = r.bt != taken;
	end
	brm_pkg::BRC_JSR: result = !r.bt;
	brm_pkg::BRC_RTD, brm_pkg::BRC_ERET: result = 1'b1;
	default: result = 1'b0;
	endcase
	return result;
endfunction

// ====================
// Stimulus table
// ====================

function automatic brm_pkg::branch_req_t make_req(input brm_pkg::brclass_t cls,
	input brm_pkg::cond_t cnd, input brm_pkg::disp_t disp, input brm_pkg::pc_t pc,
	input brm_pkg::value_t a, input brm_pkg::value_t b, input brm_pkg::value_t c,
	input logic bt);
	brm_pkg::branch_req_t r;
	r = '0;
	r.op.brclass = cls;
	r.op.cond = cnd;
	r.op.disp = disp;
	r.pc = pc;
	r.arg_a = a;
	r.arg_b = b;
	r.arg_c = c;
	r.bt = bt;
	return r;
endfunction

task automatic add_row(input brm_pkg::branch_req_t r, input brm_pkg::pc_t s0,
	input brm_pkg::pc_t s1, input int stall);
	rows[num_rows].req = r;
	rows[num_rows].stack[0] = s0;
	rows[num_rows].stack[1] = s1;
	rows[num_rows].stall = 4'(stall);
	num_rows++;
endtask

task automatic build_table();
	brm_pkg::branch_req_t r;
	brm_pkg::disp_t disp;
	brm_pkg::value_t op_a [3];
	brm_pkg::value_t op_b [3];
	brm_pkg::value_t a;
	brm_pkg::value_t b;
	brm_pkg::value_t c;
	logic [31:0] rnd;
	// Equal pair, signed-negative pair and unsigned-less pair give both outcomes
	op_a[0] = 32'd5;
	op_b[0] = 32'd5;
	op_a[1] = 32'hFFFF_FFFE;
	op_b[1] = 32'd4;
	op_a[2] = 32'd3;
	op_b[2] = 32'd7;
	num_rows = 0;
	for (int cls = 1; cls <= 2; cls++)
	begin
		for (int cnd = 0; cnd < 6; cnd++)
		begin
			for (int p = 0; p < 3; p++)
			begin
				for (int pred = 0; pred < 2; pred++)
				begin
					// The middle pair also exercises a backward displacement
					disp = (p == 1) ? 20'hFFF80 : 20'h00040;
					r = make_req(brm_pkg::brclass_t'(cls), brm_pkg::cond_t'(cnd), disp,
						32'h0001_0000 + 32'(num_rows * 64), op_a[p], op_b[p],
						32'h0002_0000 + 32'(cnd * 16 + p), pred[0]);
					add_row(r, 32'h0000_4000, 32'h0000_5000, 0);
				end
			end
		end
	end
	// Calls, returns and exception returns through both stack entries
	r = make_req(brm_pkg::BRC_JSR, brm_pkg::CND_EQ, 20'h00100, 32'h2000, 0, 0, 0, 1'b0);
	add_row(r, 32'h0000_4000, 32'h0000_5000, 0);
	r.bt = 1'b1;
	add_row(r, 32'h0000_4000, 32'h0000_5000, 0);
	r = make_req(brm_pkg::BRC_RTD, brm_pkg::CND_EQ, 0, 32'h2100, 32'h0003_4560, 0, 0, 1'b1);
	add_row(r, 32'h0000_4000, 32'h0000_5000, 0);
	r = make_req(brm_pkg::BRC_ERET, brm_pkg::CND_EQ, 0, 32'h2200, 0, 0, 0, 1'b1);
	r.op.eret_ofs = 5'd3;
	add_row(r, 32'h0000_4000, 32'h0000_5000, 0);
	r.op.eret_sel = 1'b1;
	r.op.eret_ofs = 5'd7;
	add_row(r, 32'h0000_4000, 32'h0000_5000, 0);
	r = make_req(brm_pkg::BRC_NONE, brm_pkg::CND_EQ, 0, 32'h2300, 0, 0, 0, 1'b0);
	add_row(r, 32'h0000_4000, 32'h0000_5000, 0);
	// Three misses under a held stall, then a plain row that releases it
	for (int k = 0; k < 3; k++)
	begin
		r = make_req(brm_pkg::BRC_RTD, brm_pkg::CND_EQ, 0, 32'h3000,
			32'h7000 + 32'(k * 256), 0, 0, 1'b1);
		add_row(r, 32'h0000_4000, 32'h0000_5000, 2);
	end
	r = make_req(brm_pkg::BRC_NONE, brm_pkg::CND_EQ, 0, 32'h3100, 0, 0, 0, 1'b0);
	add_row(r, 32'h0000_4000, 32'h0000_5000, 0);
	// Five misses under a held stall, the fifth one overflows the queue
	for (int k = 0; k < 5; k++)
	begin
		r = make_req(brm_pkg::BRC_JSR, brm_pkg::CND_EQ, 20'h00020,
			32'h9000 + 32'(k * 256), 0, 0, 0, 1'b0);
		add_row(r, 32'h0000_4000, 32'h0000_5000, 2);
	end
	r = make_req(brm_pkg::BRC_NONE, brm_pkg::CND_EQ, 0, 32'h3200, 0, 0, 0, 1'b0);
	add_row(r, 32'h0000_4000, 32'h0000_5000, 0);
	// Random operands and displacements, the class cycles through all branches
	for (int k = 0; k < 20; k++)
	begin
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		rnd = $random(seed);
		r = make_req(brm_pkg::brclass_t'(1 + k % 5), brm_pkg::cond_t'(k % 6), rnd[19:0],
			32'h000A_0000 + 32'(k * 128), a, b, c, k[0]);
		r.op.eret_sel = k[1];
		r.op.eret_ofs = 5'(k);
		add_row(r, 32'h0000_4000, 32'h0000_5000, 0);
	end
endtask

// ====================
// Row driver
// ====================

task automatic apply_row(input int i);
	brm_pkg::pc_t target;
	logic miss;
	test_name = $sformatf("row %0d class %0d", i, rows[i].req.op.brclass);
	miss = predict_miss(rows[i].req, rows[i].stack, target);
	@(posedge clk);
	#10;
	branch_valid = 1'b1;
	branch_req = rows[i].req;
	pc_stack = rows[i].stack;
	fetch_stall = rows[i].stall != 0;
	// A miss with the queue already holding four entries is lost
	if (miss && expect_q.size() == `BRM_FIFO_DEPTH)
		expect_ovf = 1'b1;
	else if (miss)
		expect_q.push_back(target);
	@(posedge clk);
	#10;
	branch_valid = 1'b0;
	if (rows[i].stall != 0)
		repeat (int'(rows[i].stall) - 1) @(posedge clk);
	else
	begin
		// Wait for every owed redirect, then a few quiet cycles
		while (expect_q.size() != 0)
			@(posedge clk);
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_bit("overflow", expect_ovf, overflow);
	end
endtask

// ====================
// Fetch monitor
// ====================

always @(negedge clk)
begin
	if (reset)
		started = 1'b0;
	else if (!started)
	begin
		// First cycle out of reset is the flush bubble at the reset vector
		check_pc("reset_pc", `BRM_RSTPC, fetch_pc);
		check_bit("reset_valid", 1'b0, fetch_valid);
		check_bit("reset_strobe", 1'b0, redirect_strobe);
		check_bit("reset_overflow", 1'b0, overflow);
		started = 1'b1;
		in_flush = 1'b1;
		prev_pc = fetch_pc;
		prev_stall = fetch_stall;
	end
	else
	begin
		if (redirect_strobe && expect_q.size() == 0)
		begin
			$display("Redirect strobe in %s with no miss outstanding", test_name);
			abort_run("unexpected redirect");
		end
		else if (redirect_strobe && prev_stall)
		begin
			$display("Redirect strobe in %s while fetch was stalled", test_name);
			abort_run("redirect under stall");
		end
		else if (redirect_strobe)
		begin
			owed_pc = expect_q.pop_front();
			check_pc("redirect_pc", owed_pc, fetch_pc);
			check_bit("redirect_valid", 1'b0, fetch_valid);
			in_flush = 1'b1;
		end
		else
		begin
			// Fetch holds while stalled and otherwise steps one instruction
			if (prev_stall)
				check_pc("stall_hold", prev_pc, fetch_pc);
			else
			begin
				check_pc("advance", prev_pc + `BRM_INSN_BYTES, fetch_pc);
				in_flush = 1'b0;
			end
			check_bit("fetch_valid", !in_flush && !fetch_stall, fetch_valid);
		end
		prev_pc = fetch_pc;
		prev_stall = fetch_stall;
	end
end

initial
begin
	reset = 1'b1;
	branch_valid = 1'b0;
	branch_req = '0;
	pc_stack = '0;
	fetch_stall = 1'b0;
	expect_ovf = 1'b0;
	started = 1'b0;
	in_flush = 1'b1;
	prev_stall = 1'b0;
	prev_pc = '0;
	test_name = "reset";
	seed = 46872;
	build_table();
	cycle_limit = 200;
	for (int i = 0; i < num_rows; i++)
		cycle_limit += 8 + int'(rows[i].stall);
	repeat (5) @(posedge clk);
	#10;
	reset = 1'b0;
	// Free-running fetch before the first branch
	test_name = "free_run";
	repeat (6) @(posedge clk);
	for (int i = 0; i < num_rows; i++)
		apply_row(i);
	$display("Simulation passed");
	$finish;
end

endmodule

// File: vlog.f
+incdir+.
brm_pkg.sv
branch_target_calc.sv
branch_resolve.sv
redirect_fifo.sv
fetch_sequencer.sv
branch_miss_top.sv
tb_branch_miss.sv
